/* logic/sdram_pkg.sv */
package sdram_pkg;

	// Device geometry, one x16 part with 4 banks
	localparam int BANK_W = 2;
	localparam int ROW_W  = 12;
	localparam int COL_W  = 8;

	// Bus word address, bank on top, then row, then column
	localparam int ADDR_W = BANK_W + ROW_W + COL_W;
	localparam int DATA_W = 16;

	// One mask bit per byte lane
	localparam int MASK_W = DATA_W / 8;

	// Widths of the timing fields held in the CSR block
	localparam int RP_W   = 3;
	localparam int RCD_W  = 3;
	localparam int WR_W   = 2;
	localparam int REFI_W = 11;
	// Also the width of the shared sequencer wait counter
	localparam int RFC_W  = 4;

	// Control register port
	localparam int CSR_W   = 16;
	localparam int CSR_A_W = 3;

	// Pin pattern cs_n, ras_n, cas_n, we_n (all active low)
	typedef enum logic [3:0] {
		CMD_LOAD_MODE = 4'b0000,
		CMD_REFRESH   = 4'b0001,
		CMD_PRECHARGE = 4'b0010,
		CMD_ACTIVE    = 4'b0011,
		CMD_WRITE     = 4'b0100,
		CMD_READ      = 4'b0101,
		CMD_NOP       = 4'b0111,
		CMD_DESELECT  = 4'b1111
	} sdram_cmd_e;

	// Close-page access and refresh sequencer
	typedef enum logic [3:0] {
		ST_IDLE,
		ST_ACTIVATE,
		ST_RCD_WAIT,
		ST_COMMAND,
		ST_READ_WAIT,
		ST_WR_RECOVER,
		ST_PRECHARGE,
		ST_RP_WAIT,
		ST_REFRESH,
		ST_RFC_WAIT
	} seq_state_e;

endpackage

/* logic/sdram_csr.sv */
`timescale 1ns/1ps

module sdram_csr (
	input  logic                          sys_clk,
	input  logic                          rst,
	input  logic [sdram_pkg::CSR_A_W-1:0] csr_a,
	input  logic                          csr_we,
	input  logic [sdram_pkg::CSR_W-1:0]   csr_di,
	output logic [sdram_pkg::CSR_W-1:0]   csr_do,
	output logic                          bypass,
	output logic                          sdram_rst,
	output logic                          cke,
	output sdram_pkg::sdram_cmd_e         byp_cmd,
	output logic [sdram_pkg::BANK_W-1:0]  byp_ba,
	output logic [sdram_pkg::ROW_W-1:0]   byp_adr,
	output logic [sdram_pkg::RP_W-1:0]    tim_rp,
	output logic [sdram_pkg::RCD_W-1:0]   tim_rcd,
	output logic                          tim_cas,
	output logic [sdram_pkg::WR_W-1:0]    tim_wr,
	output logic [sdram_pkg::REFI_W-1:0]  tim_refi,
	output logic [sdram_pkg::RFC_W-1:0]   tim_rfc
);
	import sdram_pkg::*;

	// Register writes
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			// Pins start under software control, device held off
			bypass    <= 1'b1;
			sdram_rst <= 1'b1;
			cke       <= 1'b0;
			byp_cmd   <= CMD_NOP;
			byp_ba    <= '0;
			byp_adr   <= '0;
			// Safe slow defaults until software programs the part
			tim_rp    <= 3'd2;
			tim_rcd   <= 3'd2;
			tim_cas   <= 1'b0;
			tim_wr    <= 2'd1;
			tim_refi  <= 11'd740;
			tim_rfc   <= 4'd8;
		end else begin
			// Bypass command lives for one cycle only
			byp_cmd <= CMD_NOP;
			if (csr_we) begin
				case (csr_a)
					3'd0: begin
						bypass    <= csr_di[0];
						sdram_rst <= csr_di[1];
						cke       <= csr_di[2];
					end
					3'd1: begin
						byp_cmd <= sdram_cmd_e'(csr_di[3:0]);
						byp_ba  <= csr_di[5:4];
					end
					3'd2: byp_adr <= csr_di[ROW_W-1:0];
					3'd3: begin
						tim_rp  <= csr_di[2:0];
						tim_rcd <= csr_di[5:3];
						// 0 selects CL2, 1 selects CL3
						tim_cas <= csr_di[6];
						tim_wr  <= csr_di[8:7];
					end
					3'd4: tim_refi <= csr_di[REFI_W-1:0];
					3'd5: tim_rfc <= csr_di[RFC_W-1:0];
					default: ;
				endcase
			end
		end
	end

	// Readback, one cycle behind the address
	always_ff @(posedge sys_clk) begin
		case (csr_a)
			3'd0: csr_do <= CSR_W'({cke, sdram_rst, bypass});
			3'd1: csr_do <= CSR_W'({byp_ba, byp_cmd});
			3'd2: csr_do <= CSR_W'(byp_adr);
			3'd3: csr_do <= CSR_W'({tim_wr, tim_cas, tim_rcd, tim_rp});
			3'd4: csr_do <= CSR_W'(tim_refi);
			3'd5: csr_do <= CSR_W'(tim_rfc);
			default: csr_do <= '0;
		endcase
	end

endmodule

/* logic/sdram_sequencer.sv */
`timescale 1ns/1ps

module sdram_sequencer (
	input  logic                          sys_clk,
	input  logic                          sdram_rst,
	input  logic                          bypass,
	input  logic [sdram_pkg::RP_W-1:0]    tim_rp,
	input  logic [sdram_pkg::RCD_W-1:0]   tim_rcd,
	input  logic [sdram_pkg::WR_W-1:0]    tim_wr,
	input  logic [sdram_pkg::REFI_W-1:0]  tim_refi,
	input  logic [sdram_pkg::RFC_W-1:0]   tim_rfc,
	input  logic                          fml_stb,
	input  logic                          fml_we,
	input  logic [sdram_pkg::ADDR_W-1:0]  fml_adr,
	input  logic                          rd_valid,
	output logic                          fml_ack,
	output sdram_pkg::sdram_cmd_e         seq_cmd,
	output logic [sdram_pkg::BANK_W-1:0]  seq_ba,
	output logic [sdram_pkg::ROW_W-1:0]   seq_adr,
	output logic                          wr_issue,
	output logic                          rd_issue
);
	import sdram_pkg::*;

	seq_state_e        state;
	// One down-counter serves tRCD, tWR, tRP and tRFC
	logic [RFC_W-1:0]  cnt;
	logic [REFI_W-1:0] refi_cnt;
	logic              refi_done;
	logic              ref_pend;
	logic [ADDR_W-1:0] adr_q;
	logic              we_q;
	logic              hold;
	logic [BANK_W-1:0] bank;
	logic [ROW_W-1:0]  row;
	logic [COL_W-1:0]  col;

	// Sequencer sleeps while software owns the pins
	assign hold = sdram_rst | bypass;
	assign {bank, row, col} = adr_q;
	assign refi_done = (refi_cnt == tim_refi - 1'b1);

	// Refresh interval, one request every tim_refi cycles
	always_ff @(posedge sys_clk) begin
		if (hold) begin
			refi_cnt <= '0;
			ref_pend <= 1'b0;
		end else begin
			refi_cnt <= refi_done ? '0 : refi_cnt + 1'b1;
			if (refi_done)
				ref_pend <= 1'b1;
			else if (state == ST_REFRESH)
				ref_pend <= 1'b0;
		end
	end

	// Request is captured in idle, master may move on after ack
	always_ff @(posedge sys_clk) begin
		if (state == ST_IDLE) begin
			adr_q <= fml_adr;
			we_q  <= fml_we;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (hold) begin
			state <= ST_IDLE;
			cnt   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Refresh wins over a waiting access
					if (ref_pend)
						state <= ST_REFRESH;
					else if (fml_stb)
						state <= ST_ACTIVATE;
				end
				ST_ACTIVATE: begin
					// ACTIVATE itself counts as the first tRCD cycle
					cnt   <= RFC_W'(tim_rcd) - 1'b1;
					state <= (tim_rcd > 3'd1) ? ST_RCD_WAIT : ST_COMMAND;
				end
				ST_RCD_WAIT: begin
					cnt <= cnt - 1'b1;
					if (cnt <= 1)
						state <= ST_COMMAND;
				end
				ST_COMMAND: begin
					if (!we_q) begin
						state <= ST_READ_WAIT;
					end else if (tim_wr != '0) begin
						cnt   <= RFC_W'(tim_wr);
						state <= ST_WR_RECOVER;
					end else begin
						state <= ST_PRECHARGE;
					end
				end
				ST_READ_WAIT: begin
					if (rd_valid)
						state <= ST_PRECHARGE;
				end
				ST_WR_RECOVER: begin
					cnt <= cnt - 1'b1;
					if (cnt <= 1)
						state <= ST_PRECHARGE;
				end
				ST_PRECHARGE: begin
					cnt   <= RFC_W'(tim_rp);
					state <= (tim_rp != '0) ? ST_RP_WAIT : ST_IDLE;
				end
				ST_REFRESH: begin
					cnt   <= tim_rfc;
					state <= (tim_rfc != '0) ? ST_RFC_WAIT : ST_IDLE;
				end
				// tRP and tRFC both end back in idle
				ST_RP_WAIT, ST_RFC_WAIT: begin
					cnt <= cnt - 1'b1;
					if (cnt <= 1)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Commands decode from state
	always_comb begin
		seq_cmd = CMD_NOP;
		seq_adr = '0;
		case (state)
			ST_ACTIVATE: begin
				seq_cmd = CMD_ACTIVE;
				seq_adr = row;
			end
			ST_COMMAND: begin
				seq_cmd = we_q ? CMD_WRITE : CMD_READ;
				// Bit 10 stays low, no auto precharge
				seq_adr = ROW_W'(col);
			end
			// Bit 10 low closes only the addressed bank
			ST_PRECHARGE: seq_cmd = CMD_PRECHARGE;
			ST_REFRESH:   seq_cmd = CMD_REFRESH;
			default: ;
		endcase
	end

	assign seq_ba   = bank;
	assign wr_issue = (state == ST_COMMAND) && we_q;
	assign rd_issue = (state == ST_COMMAND) && !we_q;
	// Writes ack at issue, reads when the word comes back
	assign fml_ack  = wr_issue | ((state == ST_READ_WAIT) && rd_valid);

endmodule

/* logic/sdram_dataio.sv */
`timescale 1ns/1ps

module sdram_dataio (
	input  logic                         sys_clk,
	input  logic                         sdram_rst,
	input  logic                         tim_cas,
	input  logic                         wr_issue,
	input  logic                         rd_issue,
	input  logic [sdram_pkg::DATA_W-1:0] fml_di,
	input  logic [sdram_pkg::MASK_W-1:0] fml_sel,
	output logic [sdram_pkg::DATA_W-1:0] fml_do,
	output logic                         rd_valid,
	output logic [sdram_pkg::MASK_W-1:0] sdram_dqm,
	inout  wire  [sdram_pkg::DATA_W-1:0] sdram_dq
);
	import sdram_pkg::*;

	logic [DATA_W-1:0] dq_out;
	logic              dq_oe;
	// Tracks a READ from issue through pin register and CAS latency
	logic [3:0]        rd_sr;
	logic              rd_tap;

	// Drive enable and mask line up with WRITE at the pins
	always_ff @(posedge sys_clk) begin
		if (sdram_rst) begin
			dq_oe     <= 1'b0;
			sdram_dqm <= '0;
		end else begin
			dq_oe     <= wr_issue;
			// FML select is active high, DQM masks when high
			sdram_dqm <= wr_issue ? ~fml_sel : '0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr_issue)
			dq_out <= fml_di;
	end

	// Bus released one cycle after the write word
	assign sdram_dq = dq_oe ? dq_out : 'z;

	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			rd_sr <= '0;
		else
			rd_sr <= {rd_sr[2:0], rd_issue};
	end

	// Tap sits one cycle before the word is registered
	assign rd_tap = tim_cas ? rd_sr[3] : rd_sr[2];

	always_ff @(posedge sys_clk) begin
		if (sdram_rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_tap;
	end

	// Input register, word valid with rd_valid
	always_ff @(posedge sys_clk) begin
		if (rd_tap)
			fml_do <= sdram_dq;
	end

endmodule

/* logic/sdram_ctrl.sv */
`timescale 1ns/1ps

module sdram_ctrl (
	input  logic                          sys_clk,
	input  logic                          rst,
	input  logic [sdram_pkg::CSR_A_W-1:0] csr_a,
	input  logic                          csr_we,
	input  logic [sdram_pkg::CSR_W-1:0]   csr_di,
	output logic [sdram_pkg::CSR_W-1:0]   csr_do,
	input  logic [sdram_pkg::ADDR_W-1:0]  fml_adr,
	input  logic                          fml_stb,
	input  logic                          fml_we,
	output logic                          fml_ack,
	input  logic [sdram_pkg::MASK_W-1:0]  fml_sel,
	input  logic [sdram_pkg::DATA_W-1:0]  fml_di,
	output logic [sdram_pkg::DATA_W-1:0]  fml_do,
	output logic                          sdram_cke,
	output logic                          sdram_cs_n,
	output logic                          sdram_ras_n,
	output logic                          sdram_cas_n,
	output logic                          sdram_we_n,
	output logic [sdram_pkg::BANK_W-1:0]  sdram_ba,
	output logic [sdram_pkg::ROW_W-1:0]   sdram_adr,
	output logic [sdram_pkg::MASK_W-1:0]  sdram_dqm,
	inout  wire  [sdram_pkg::DATA_W-1:0]  sdram_dq
);
	import sdram_pkg::*;

	logic              bypass;
	logic              sdram_rst;
	logic              cke;
	sdram_cmd_e        byp_cmd;
	sdram_cmd_e        seq_cmd;
	sdram_cmd_e        cmd_mux;
	logic [BANK_W-1:0] byp_ba;
	logic [BANK_W-1:0] seq_ba;
	logic [ROW_W-1:0]  byp_adr;
	logic [ROW_W-1:0]  seq_adr;
	logic [RP_W-1:0]   tim_rp;
	logic [RCD_W-1:0]  tim_rcd;
	logic              tim_cas;
	logic [WR_W-1:0]   tim_wr;
	logic [REFI_W-1:0] tim_refi;
	logic [RFC_W-1:0]  tim_rfc;
	logic              wr_issue;
	logic              rd_issue;
	logic              rd_valid;

	sdram_csr u_csr (
		.sys_clk(sys_clk), .rst(rst),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.bypass(bypass), .sdram_rst(sdram_rst), .cke(cke),
		.byp_cmd(byp_cmd), .byp_ba(byp_ba), .byp_adr(byp_adr),
		.tim_rp(tim_rp), .tim_rcd(tim_rcd), .tim_cas(tim_cas),
		.tim_wr(tim_wr), .tim_refi(tim_refi), .tim_rfc(tim_rfc)
	);

	sdram_sequencer u_seq (
		.sys_clk(sys_clk), .sdram_rst(sdram_rst), .bypass(bypass),
		.tim_rp(tim_rp), .tim_rcd(tim_rcd), .tim_wr(tim_wr),
		.tim_refi(tim_refi), .tim_rfc(tim_rfc),
		.fml_stb(fml_stb), .fml_we(fml_we), .fml_adr(fml_adr),
		.rd_valid(rd_valid), .fml_ack(fml_ack),
		.seq_cmd(seq_cmd), .seq_ba(seq_ba), .seq_adr(seq_adr),
		.wr_issue(wr_issue), .rd_issue(rd_issue)
	);

	sdram_dataio u_dataio (
		.sys_clk(sys_clk), .sdram_rst(sdram_rst), .tim_cas(tim_cas),
		.wr_issue(wr_issue), .rd_issue(rd_issue),
		.fml_di(fml_di), .fml_sel(fml_sel), .fml_do(fml_do), .rd_valid(rd_valid),
		.sdram_dqm(sdram_dqm), .sdram_dq(sdram_dq)
	);

	// Software or sequencer owns the pins, CKE is always software
	assign cmd_mux = bypass ? byp_cmd : seq_cmd;

	// Single register stage so the pins can sit in I/O flops
	always_ff @(posedge sys_clk) begin
		if (rst) begin
			sdram_cke <= 1'b0;
			{sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= CMD_NOP;
		end else begin
			sdram_cke <= cke;
			{sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= cmd_mux;
		end
	end

	always_ff @(posedge sys_clk) begin
		sdram_ba  <= bypass ? byp_ba : seq_ba;
		sdram_adr <= bypass ? byp_adr : seq_adr;
	end

endmodule

/* bench/sdram_model.sv */
`timescale 1ns/1ps

module sdram_model (
	input  logic                         sys_clk,
	input  logic                         cke,
	input  logic                         cs_n,
	input  logic                         ras_n,
	input  logic                         cas_n,
	input  logic                         we_n,
	input  logic [sdram_pkg::BANK_W-1:0] ba,
	input  logic [sdram_pkg::ROW_W-1:0]  adr,
	input  logic [sdram_pkg::MASK_W-1:0] dqm,
	inout  wire  [sdram_pkg::DATA_W-1:0] dq
);
	import sdram_pkg::*;

	// Sparse storage, a word never written reads as zero
	logic [DATA_W-1:0] mem [int];
	logic [ROW_W-1:0]  open_row [1 << BANK_W];
	logic [2:0]        cas_lat;
	logic [1:0]        rd_cnt;
	logic [DATA_W-1:0] rd_word;
	logic [DATA_W-1:0] dq_drv;
	logic              dq_oe;
	logic [DATA_W-1:0] cur;
	int                key;
	sdram_cmd_e        cmd;
	// Every decoded command other than NOP, in order
	sdram_cmd_e        cmd_log [$];

	assign cmd = cs_n ? CMD_DESELECT : sdram_cmd_e'({cs_n, ras_n, cas_n, we_n});

	initial begin
		cas_lat = 3'd2;
		rd_cnt  = 2'd0;
		dq_oe   = 1'b0;
	end

	always @(posedge sys_clk) begin
		// Word goes out one edge before the CAS latency edge
		dq_oe  <= (rd_cnt == 2'd1);
		dq_drv <= rd_word;
		if (rd_cnt != 2'd0)
			rd_cnt <= rd_cnt - 2'd1;
		if (cke) begin
			if (cmd != CMD_NOP && cmd != CMD_DESELECT)
				cmd_log.push_back(cmd);
			key = int'({ba, open_row[ba], adr[COL_W-1:0]});
			case (cmd)
				CMD_ACTIVE: open_row[ba] <= adr;
				// CAS latency field of the mode word
				CMD_LOAD_MODE: cas_lat <= adr[6:4];
				CMD_WRITE: begin
					cur = mem.exists(key) ? mem[key] : '0;
					// DQM high masks the lane
					if (!dqm[0])
						cur[7:0] = dq[7:0];
					if (!dqm[1])
						cur[15:8] = dq[15:8];
					mem[key] = cur;
				end
				CMD_READ: begin
					rd_word <= mem.exists(key) ? mem[key] : '0;
					rd_cnt  <= 2'(cas_lat - 3'd1);
				end
				default: ;
			endcase
		end
	end

	assign dq = dq_oe ? dq_drv : 'z;

endmodule

/* bench/sdram_ctrl_asserts.sv */
`timescale 1ns/1ps

module sdram_ctrl_asserts (
	input logic                  sys_clk,
	input logic                  sdram_rst,
	input logic                  bypass,
	input logic                  fml_stb,
	input logic                  fml_ack,
	input sdram_pkg::sdram_cmd_e seq_cmd,
	input sdram_pkg::seq_state_e state
);
	import sdram_pkg::*;

	// High between ACTIVE and its PRECHARGE
	logic row_open;

	always_ff @(posedge sys_clk) begin
		if (sdram_rst || bypass)
			row_open <= 1'b0;
		else if (seq_cmd == CMD_ACTIVE)
			row_open <= 1'b1;
		else if (seq_cmd == CMD_PRECHARGE)
			row_open <= 1'b0;
	end

	ack_with_stb: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		fml_ack |-> fml_stb)
		else $error("fml_ack without strobe");

	ack_one_cycle: assert property (@(posedge sys_clk) disable iff (sdram_rst)
		fml_ack |=> !fml_ack)
		else $error("fml_ack held longer than one cycle");

	nop_in_reset: assert property (@(posedge sys_clk)
		sdram_rst |-> seq_cmd == CMD_NOP)
		else $error("sequencer command other than NOP during SDRAM reset");

	no_double_active: assert property (@(posedge sys_clk) disable iff (sdram_rst || bypass)
		seq_cmd == CMD_ACTIVE |-> !row_open)
		else $error("ACTIVE issued while a row is still open");

	// All banks must be idle before auto-refresh
	refresh_banks_closed: assert property (@(posedge sys_clk) disable iff (sdram_rst || bypass)
		state == ST_REFRESH |-> !row_open)
		else $error("REFRESH issued while a row is still open");

endmodule

bind sdram_sequencer sdram_ctrl_asserts u_asserts (
	.sys_clk(sys_clk), .sdram_rst(sdram_rst), .bypass(bypass),
	.fml_stb(fml_stb), .fml_ack(fml_ack), .seq_cmd(seq_cmd), .state(state)
);

/* bench/sdram_ctrl_tb.sv */
`timescale 1ns/1ps

module sdram_ctrl_tb;
	import sdram_pkg::*;

	localparam int          CYCLE_LIMIT = 20000;
	localparam logic [31:0] SEED        = 32'h20773d61;
	// tRP 2, tRCD 3, tWR 2, with CL2 or CL3
	localparam logic [15:0] TIM_CL2     = 16'h011A;
	localparam logic [15:0] TIM_CL3     = 16'h015A;

	logic                sys_clk;
	logic                rst;
	logic [CSR_A_W-1:0]  csr_a;
	logic                csr_we;
	logic [CSR_W-1:0]    csr_di;
	logic [CSR_W-1:0]    csr_do;
	logic [ADDR_W-1:0]   fml_adr;
	logic                fml_stb;
	logic                fml_we;
	logic                fml_ack;
	logic [MASK_W-1:0]   fml_sel;
	logic [DATA_W-1:0]   fml_di;
	logic [DATA_W-1:0]   fml_do;
	logic                sdram_cke;
	logic                sdram_cs_n;
	logic                sdram_ras_n;
	logic                sdram_cas_n;
	logic                sdram_we_n;
	logic [BANK_W-1:0]   sdram_ba;
	logic [ROW_W-1:0]    sdram_adr;
	logic [MASK_W-1:0]   sdram_dqm;
	wire  [DATA_W-1:0]   sdram_dq;

	logic [31:0]         lfsr;
	int                  cycles;
	string               test_name;
	// Expected memory image and reads still waiting for their ack
	logic [DATA_W-1:0]   ref_mem [int];
	logic [DATA_W-1:0]   exp_q [$];
	string               name_q [$];
	sdram_cmd_e          init_cmds [4] = '{CMD_PRECHARGE, CMD_REFRESH, CMD_REFRESH,
		CMD_LOAD_MODE};

	sdram_ctrl UUT (
		.sys_clk(sys_clk), .rst(rst),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.fml_adr(fml_adr), .fml_stb(fml_stb), .fml_we(fml_we), .fml_ack(fml_ack),
		.fml_sel(fml_sel), .fml_di(fml_di), .fml_do(fml_do),
		.sdram_cke(sdram_cke), .sdram_cs_n(sdram_cs_n), .sdram_ras_n(sdram_ras_n),
		.sdram_cas_n(sdram_cas_n), .sdram_we_n(sdram_we_n), .sdram_ba(sdram_ba),
		.sdram_adr(sdram_adr), .sdram_dqm(sdram_dqm), .sdram_dq(sdram_dq)
	);

	sdram_model dev (
		.sys_clk(sys_clk), .cke(sdram_cke), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n),
		.cas_n(sdram_cas_n), .we_n(sdram_we_n), .ba(sdram_ba), .adr(sdram_adr),
		.dqm(sdram_dqm), .dq(sdram_dq)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Run limit, well above the length of all tests together
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge sys_clk);
			cycles++;
		end
		$display("Verification failed");
		$fatal(1, "Timeout, tests did not finish within %0d cycles", CYCLE_LIMIT);
	end

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("Verification failed");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	// Galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Merges a write into the image, or returns the stored word for a read
	function automatic logic [DATA_W-1:0] exp_word(input logic [ADDR_W-1:0] adr,
			input logic we, input logic [MASK_W-1:0] sel, input logic [DATA_W-1:0] di);
		logic [DATA_W-1:0] w;
		w = ref_mem.exists(int'(adr)) ? ref_mem[int'(adr)] : '0;
		if (we) begin
			if (sel[0])
				w[7:0] = di[7:0];
			if (sel[1])
				w[15:8] = di[15:8];
			ref_mem[int'(adr)] = w;
		end
		return w;
	endfunction

	// First and last words of a bank, row and column boundaries
	function automatic logic [ADDR_W-1:0] edge_adr(input logic [1:0] b, input int k);
		case (k)
			0: return {b, 12'h000, 8'h00};
			1: return {b, 12'h7FF, 8'hFF};
			2: return {b, 12'h800, 8'h00};
			3: return {b, 12'hFFF, 8'hFF};
			4: return {b, 12'h123, 8'h7F};
			default: return {b, 12'h123, 8'h80};
		endcase
	endfunction

	task automatic csr_write(input logic [CSR_A_W-1:0] a, input logic [CSR_W-1:0] d);
		@(posedge sys_clk);
		csr_a  <= a;
		csr_di <= d;
		csr_we <= 1'b1;
		@(posedge sys_clk);
		csr_we <= 1'b0;
	endtask

	task automatic csr_read(input logic [CSR_A_W-1:0] a, output logic [CSR_W-1:0] d);
		@(posedge sys_clk);
		csr_a  <= a;
		csr_we <= 1'b0;
		// Address lands on the first edge, readback register on the second
		repeat (2) @(posedge sys_clk);
		d = csr_do;
	endtask

	task automatic bypass_cmd(input sdram_cmd_e cmd, input logic [ROW_W-1:0] adr);
		csr_write(3'd2, {4'h0, adr});
		csr_write(3'd1, {12'h000, cmd});
	endtask

	task automatic wait_ack;
		@(posedge sys_clk);
		while (!fml_ack)
			@(posedge sys_clk);
		fml_stb <= 1'b0;
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [MASK_W-1:0] sel,
			input logic [DATA_W-1:0] di);
		void'(exp_word(adr, 1'b1, sel, di));
		@(posedge sys_clk);
		fml_adr <= adr;
		fml_we  <= 1'b1;
		fml_sel <= sel;
		fml_di  <= di;
		fml_stb <= 1'b1;
		wait_ack();
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] adr);
		exp_q.push_back(exp_word(adr, 1'b0, 2'b00, 16'h0000));
		name_q.push_back($sformatf("%s read %06h", test_name, adr));
		@(posedge sys_clk);
		fml_adr <= adr;
		fml_we  <= 1'b0;
		fml_stb <= 1'b1;
		wait_ack();
	endtask

	task automatic random_traffic(input int n);
		logic [31:0]       b;
		logic [31:0]       r;
		logic [31:0]       c;
		logic [31:0]       op;
		logic [31:0]       sel;
		logic [31:0]       data;
		logic [ADDR_W-1:0] adr;
		int                i;
		for (i = 0; i < n; i++) begin
			b  = rand_bits(2);
			r  = rand_bits(2);
			c  = rand_bits(3);
			op = rand_bits(1);
			// Small pool of words so reads hit earlier writes
			adr = {b[1:0], r[1:0], 10'h3F0, c[2:0], 5'h0A};
			if (op[0]) begin
				sel  = rand_bits(2);
				data = rand_bits(16);
				bus_write(adr, sel[1:0], data[15:0]);
			end else begin
				bus_read(adr);
			end
		end
	endtask

	// Read data compared in the ack cycle
	always @(posedge sys_clk) begin
		if (fml_stb && fml_ack && !fml_we)
			check(name_q.pop_front(), 32'(exp_q.pop_front()), 32'(fml_do));
	end

	initial begin
		logic [CSR_W-1:0] d;
		logic [31:0]      rnd;
		int               b;
		int               k;
		int               i;
		int               start;
		int               refs;
		rst     = 1'b1;
		csr_a   = '0;
		csr_we  = 1'b0;
		csr_di  = '0;
		fml_adr = '0;
		fml_stb = 1'b0;
		fml_we  = 1'b0;
		fml_sel = '0;
		fml_di  = '0;
		lfsr    = SEED;
		repeat (5) @(posedge sys_clk);
		rst <= 1'b0;

		// Reset values and timing readback
		test_name = "csr";
		csr_read(3'd0, d);
		check("csr control after reset", 32'd3, 32'(d));
		csr_write(3'd3, TIM_CL2);
		csr_write(3'd4, 16'd200);
		csr_write(3'd5, 16'd7);
		csr_read(3'd3, d);
		check("csr timing", 32'(TIM_CL2), 32'(d));
		csr_read(3'd4, d);
		check("csr refresh interval", 32'd200, 32'(d));
		csr_read(3'd5, d);
		check("csr refresh cycle", 32'd7, 32'(d));

		// Power-up sequence by software, mode word with CL2 and BL1
		start = dev.cmd_log.size();
		csr_write(3'd0, 16'h0007);
		bypass_cmd(CMD_PRECHARGE, 12'h400);
		bypass_cmd(CMD_REFRESH, 12'h000);
		bypass_cmd(CMD_REFRESH, 12'h000);
		bypass_cmd(CMD_LOAD_MODE, 12'h020);
		// CSR pulse, then pin register, then model decode
		repeat (4) @(posedge sys_clk);
		check("bypass init count", 32'd4, 32'(dev.cmd_log.size() - start));
		for (i = 0; i < 4; i++)
			check($sformatf("bypass init cmd %0d", i), 32'(init_cmds[i]),
				32'(dev.cmd_log[start + i]));
		csr_write(3'd0, 16'h0004);

		test_name = "single";
		for (b = 0; b < 4; b++) begin
			for (k = 0; k < 6; k++) begin
				rnd = rand_bits(16);
				bus_write(edge_adr(b[1:0], k), 2'b11, rnd[15:0]);
			end
		end
		for (b = 0; b < 4; b++) begin
			for (k = 0; k < 6; k++)
				bus_read(edge_adr(b[1:0], k));
		end

		test_name = "lanes";
		bus_write(22'h2A5A5A, 2'b11, 16'h1234);
		bus_write(22'h2A5A5A, 2'b01, 16'hABCD);
		bus_read(22'h2A5A5A);
		bus_write(22'h2A5A5A, 2'b10, 16'h5678);
		bus_read(22'h2A5A5A);
		bus_write(22'h2A5A5A, 2'b11, 16'h9ABC);
		bus_read(22'h2A5A5A);

		test_name = "random cl2";
		random_traffic(200);
		// Let the last precharge or refresh run out
		repeat (16) @(posedge sys_clk);
		csr_write(3'd0, 16'h0005);
		bypass_cmd(CMD_PRECHARGE, 12'h400);
		bypass_cmd(CMD_LOAD_MODE, 12'h030);
		csr_write(3'd3, TIM_CL3);
		csr_write(3'd0, 16'h0004);
		test_name = "random cl3";
		random_traffic(200);

		// Idle bus, one refresh per 200 cycles
		test_name = "refresh";
		start = dev.cmd_log.size();
		repeat (2000) @(posedge sys_clk);
		refs = 0;
		for (i = start; i < dev.cmd_log.size(); i++) begin
			if (dev.cmd_log[i] == CMD_REFRESH)
				refs++;
		end
		// Within one of ten counts as ten
		check("refresh count", 32'd10, (refs >= 9 && refs <= 11) ? 32'd10 : 32'(refs));

		$display("Verification passed");
		$finish;
	end

endmodule

/* sources.f */
logic/sdram_pkg.sv
logic/sdram_csr.sv
logic/sdram_sequencer.sv
logic/sdram_dataio.sv
logic/sdram_ctrl.sv
bench/sdram_model.sv
bench/sdram_ctrl_asserts.sv
bench/sdram_ctrl_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= sdram_ctrl_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
